// ==== bench/tb_checks.svh ====
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

// Fibonacci LFSR, x^17 + x^14 + 1, shifts left with feedback into bit 0
function automatic logic [16:0] lfsr_step(input logic [16:0] s);
  lfsr_step = {s[15:0], s[16] ^ s[13]};
endfunction

// One random bit per call, state advances once
function logic take_bit();
  take_bit = lfsr[16];
  lfsr     = lfsr_step(lfsr);
endfunction

task automatic check_hsk(input string name, input usb_xfer_pkg::hsk_e exp,
                         input usb_xfer_pkg::hsk_e act);
  if (act !== exp) begin
    $display("ERROR at %0d ns: %s expected %s got %s", $time, name,
             exp.name(), act.name());
    stop_with_fail("handshake type mismatch");
  end
endtask

task automatic check_pid(input string name, input usb_xfer_pkg::pid_e exp,
                         input usb_xfer_pkg::pid_e act);
  if (act !== exp) begin
    $display("ERROR at %0d ns: %s expected %s got %s", $time, name,
             exp.name(), act.name());
    stop_with_fail("data PID mismatch");
  end
endtask

task automatic check_err(input string name, input usb_xfer_pkg::err_e exp,
                         input usb_xfer_pkg::err_e act);
  if (act !== exp) begin
    $display("ERROR at %0d ns: %s expected %s got %s", $time, name,
             exp.name(), act.name());
    stop_with_fail("error code mismatch");
  end
endtask

task automatic check_byte(input string name, input logic [usb_xfer_pkg::BYTE_W-1:0] exp,
                          input logic [usb_xfer_pkg::BYTE_W-1:0] act);
  if (act !== exp) begin
    $display("ERROR at %0d ns: %s expected 0x%02h got 0x%02h", $time, name, exp, act);
    stop_with_fail("data byte mismatch");
  end
endtask

// Stream end marker
task automatic check_bit(input string name, input logic exp, input logic act);
  if (act !== exp) begin
    $display("ERROR at %0d ns: %s expected %b got %b", $time, name, exp, act);
    stop_with_fail("tlast flag mismatch");
  end
endtask

`endif

// ==== bench/tb_usb_transaction.sv ====
module tb_usb_transaction;
  timeunit 1ns;
  timeprecision 100ps;

  localparam logic [6:0] DEV_ADDR = 7'h05;
  // Count word, then 16 words per transaction
  localparam int REC_W = 16;
  localparam int MAX_REC = 32;

  logic clock;
  logic reset;
  logic tok_recv_i, hsk_recv_i, hsk_sent_i, usb_sent_i;
  logic [6:0] tok_addr_i;
  logic [3:0] tok_endp_i;
  usb_xfer_pkg::token_e tok_type_i;
  usb_xfer_pkg::hsk_e hsk_type_i, hsk_type_o;
  usb_xfer_pkg::pid_e usb_type_o;
  usb_xfer_pkg::err_e err_code_o;
  logic hsk_send_o, usb_send_o, blk_start_o, ctl_start_o;
  logic usb_tvalid_i, usb_tready_o, usb_tlast_i, usb_tvalid_o, usb_tready_i, usb_tlast_o;
  logic blk_in_ready_i, blk_out_ready_i, blk_tvalid_o, blk_tready_i, blk_tlast_o;
  logic blk_tvalid_i, blk_tready_o, blk_tlast_i;
  logic [7:0] usb_tdata_i, usb_tdata_o, blk_tdata_o, blk_tdata_i, ctl_rtype_o, ctl_rargs_o;
  logic [15:0] ctl_value_o, ctl_index_o, ctl_length_o;

  logic [7:0] vec [0:MAX_REC*REC_W];
  logic [16:0] lfsr = 17'd75349;
  usb_xfer_pkg::hsk_e hsk_q [$];
  usb_xfer_pkg::pid_e pid_q [$];
  logic [7:0] out_q [$];
  logic [7:0] in_q [$];
  // tlast seen with each accepted byte
  logic out_last_q [$];
  logic in_last_q [$];
  int blk_seen, start_count, cycles, limit, n_rec, n_bytes;
  logic sent_prev, start_late, toggle;

  `include "tb_checks.svh"

  usb_transaction_top UUT (.*, .usb_addr_i(DEV_ADDR));

  always #10 clock = ~clock;

  task automatic stop_with_fail(input string why);
    $display("%s", why);
    $display(">>> FAIL");
    $fatal(1);
  endtask

  // Host side: sent pulses, captured requests, random back-pressure
  always @(negedge clock) begin
    if (reset) begin
      hsk_sent_i = 1'b0;
      usb_sent_i = 1'b0;
    end else begin
      hsk_sent_i = hsk_send_o && !hsk_sent_i;
      if (hsk_sent_i) hsk_q.push_back(hsk_type_o);
      usb_sent_i = usb_send_o && !usb_sent_i;
      if (usb_sent_i) pid_q.push_back(usb_type_o);
    end
    usb_tready_i = take_bit();
    blk_tready_i = take_bit();
  end

  // Stream capture, start pulse timing and the cycle limit
  always @(posedge clock) begin
    if (!reset) begin
      if (blk_tvalid_o) begin
        blk_seen++;
        if (blk_tready_i) begin
          out_q.push_back(blk_tdata_o);
          out_last_q.push_back(blk_tlast_o);
        end
      end
      if (usb_tvalid_o && usb_tready_i) begin
        in_q.push_back(usb_tdata_o);
        in_last_q.push_back(usb_tlast_o);
      end
      if (ctl_start_o) begin
        start_count++;
        if (!sent_prev) start_late = 1'b1;
      end
    end
    sent_prev = hsk_sent_i;
    cycles++;
    if (cycles > limit) stop_with_fail("Timeout: the run took too many clock cycles");
  end

  // Decoder side receive stream, one byte per accepted cycle
  task automatic send_rx(input int base, input int cnt);
    for (int i = 0; i < cnt; i++) begin
      usb_tvalid_i = 1'b1;
      usb_tdata_i  = vec[base + 5 + i];
      usb_tlast_i  = i == cnt - 1;
      @(posedge clock);
      while (!usb_tready_o) @(posedge clock);
      @(negedge clock);
    end
    usb_tvalid_i = 1'b0;
    usb_tlast_i  = 1'b0;
  endtask

  // Bulk IN source
  task automatic send_src(input int base, input int cnt);
    for (int i = 0; i < cnt; i++) begin
      blk_tvalid_i = 1'b1;
      blk_tdata_i  = vec[base + 5 + i];
      blk_tlast_i  = i == cnt - 1;
      @(posedge clock);
      while (!blk_tready_o) @(posedge clock);
      @(negedge clock);
    end
    blk_tvalid_i = 1'b0;
    blk_tlast_i  = 1'b0;
  endtask

  task automatic run_record(input int base);
    logic [7:0] kind, addr, endp, rdy, cnt, e_hsk, e_pid, e_err;
    int hsk0, pid0, start0;
    logic ok;
    kind  = vec[base];
    addr  = vec[base + 1];
    endp  = vec[base + 2];
    rdy   = vec[base + 3];
    cnt   = vec[base + 4];
    e_hsk = vec[base + 13];
    e_pid = vec[base + 14];
    e_err = vec[base + 15];
    blk_in_ready_i  = rdy[0];
    blk_out_ready_i = rdy[0];
    hsk0 = hsk_q.size();
    pid0 = pid_q.size();
    start0 = start_count;
    out_q.delete();
    in_q.delete();
    out_last_q.delete();
    in_last_q.delete();
    blk_seen = 0;
    // Token for one cycle
    tok_recv_i = 1'b1;
    tok_type_i = usb_xfer_pkg::token_e'(kind[1:0]);
    tok_addr_i = addr[6:0];
    tok_endp_i = endp[3:0];
    @(negedge clock);
    tok_recv_i = 1'b0;
    ok = addr[6:0] == DEV_ADDR &&
         ((kind != 8'd3 && kind != 8'd1 && endp == 8'd1) || (kind == 8'd3 && endp == 8'd0));
    if (blk_start_o !== (ok && kind != 8'd3)) begin
      stop_with_fail("blk_start_o wrong in the cycle after the token");
    end
    @(negedge clock);
    if (!ok) begin
      repeat (10) @(negedge clock);
    end else if (kind == 8'd0) begin
      send_rx(base, cnt);
      while (hsk_q.size() == hsk0) @(negedge clock);
      if (rdy[0]) begin
        if (out_q.size() != cnt) stop_with_fail("Bulk OUT byte count wrong on blk stream");
        for (int i = 0; i < cnt; i++) begin
          check_byte("blk_tdata_o", vec[base + 5 + i], out_q[i]);
          check_bit("blk_tlast_o", i == cnt - 1, out_last_q[i]);
        end
        toggle = ~toggle;
      end else if (blk_seen != 0) begin
        stop_with_fail("blk_tvalid_o raised for a refused OUT packet");
      end
    end else if (kind == 8'd2) begin
      while (pid_q.size() == pid0) @(negedge clock);
      check_pid("usb_type_o", toggle ? usb_xfer_pkg::PID_DATA1 : usb_xfer_pkg::PID_DATA0,
                pid_q[pid0]);
      if (rdy[0]) send_src(base, cnt);
      else @(negedge clock);
      if (in_q.size() != (rdy[0] ? cnt : 0)) stop_with_fail("Bulk IN byte count wrong");
      for (int i = 0; i < in_q.size(); i++) begin
        check_byte("usb_tdata_o", vec[base + 5 + i], in_q[i]);
        check_bit("usb_tlast_o", i == cnt - 1, in_last_q[i]);
      end
      hsk_recv_i = 1'b1;
      hsk_type_i = usb_xfer_pkg::HSK_ACK;
      @(negedge clock);
      hsk_recv_i = 1'b0;
      toggle = ~toggle;
    end else begin
      send_rx(base, cnt);
      while (hsk_q.size() == hsk0) @(negedge clock);
      while (start_count == start0) @(negedge clock);
      check_byte("ctl_rtype_o", vec[base + 5], ctl_rtype_o);
      check_byte("ctl_rargs_o", vec[base + 6], ctl_rargs_o);
      check_byte("ctl_value_o[7:0]", vec[base + 7], ctl_value_o[7:0]);
      check_byte("ctl_value_o[15:8]", vec[base + 8], ctl_value_o[15:8]);
      check_byte("ctl_index_o[7:0]", vec[base + 9], ctl_index_o[7:0]);
      check_byte("ctl_index_o[15:8]", vec[base + 10], ctl_index_o[15:8]);
      check_byte("ctl_length_o[7:0]", vec[base + 11], ctl_length_o[7:0]);
      check_byte("ctl_length_o[15:8]", vec[base + 12], ctl_length_o[15:8]);
    end
    // Handshake and PID against the vector file
    if (e_hsk == 8'h03) begin
      if (hsk_q.size() != hsk0) stop_with_fail("Unexpected handshake from the device");
    end else begin
      check_hsk("hsk_type_o", usb_xfer_pkg::hsk_e'(e_hsk[1:0]), hsk_q[hsk0]);
    end
    if (e_pid == 8'h03) begin
      if (pid_q.size() != pid0) stop_with_fail("Unexpected data packet from the device");
    end else begin
      check_pid("usb_type_o", usb_xfer_pkg::pid_e'(e_pid[1:0]), pid_q[pid0]);
    end
    check_err("err_code_o", usb_xfer_pkg::err_e'(e_err[1:0]), err_code_o);
    repeat (3) @(negedge clock);
    // Exactly one start pulse for a full setup packet, none otherwise
    if (start_late || start_count != start0 + int'(ok && kind == 8'd3 && cnt == 8'd8)) begin
      stop_with_fail("ctl_start_o pulse count or timing is wrong");
    end
  endtask

  initial begin
    clock = 1'b0;
    reset = 1'b1;
    {tok_recv_i, hsk_recv_i, hsk_sent_i, usb_sent_i} = '0;
    tok_type_i = usb_xfer_pkg::TOK_OUT;
    tok_addr_i = '0;
    tok_endp_i = '0;
    hsk_type_i = usb_xfer_pkg::HSK_ACK;
    {usb_tvalid_i, usb_tlast_i, usb_tdata_i, usb_tready_i} = '0;
    {blk_in_ready_i, blk_out_ready_i, blk_tready_i} = '0;
    {blk_tvalid_i, blk_tlast_i, blk_tdata_i} = '0;
    {blk_seen, start_count, cycles, n_bytes} = '0;
    sent_prev = 1'b0;
    start_late = 1'b0;
    toggle = 1'b0;
    limit = 1000000;
    $readmemh("bench/usb_vectors.txt", vec);
    // Records up to the leading count, stopping at the first one not fully loaded
    n_rec = 0;
    while (n_rec < int'(vec[0]) && n_rec < MAX_REC &&
           !$isunknown(vec[(n_rec + 1) * REC_W])) begin
      n_rec++;
    end
    if (n_rec == 0) stop_with_fail("Vector file holds no transactions");
    for (int r = 0; r < n_rec; r++) n_bytes += vec[1 + r * REC_W + 4];
    limit = 16 + 40 * n_rec + 4 * n_bytes;
    repeat (16) @(negedge clock);
    reset = 1'b0;
    for (int r = 0; r < n_rec; r++) run_record(1 + r * REC_W);
    $display(">>> PASS");
    $finish;
  end

endmodule

// ==== bench/usb_vectors.txt ====
// kind(0 OUT,1 SOF,2 IN,3 SETUP) addr endp ready count b0..b7
// exp_hsk(0 ACK,2 NAK,3 none) exp_pid(0 DATA0,2 DATA1,3 none) exp_err
13
00 05 01 01 04 11 22 33 44 00 00 00 00 00 03 00
00 05 01 00 03 55 66 77 00 00 00 00 00 02 03 00
02 05 01 01 04 a1 a2 a3 a4 00 00 00 00 03 02 00
02 05 01 01 02 b1 b2 00 00 00 00 00 00 03 00 00
02 05 01 00 00 00 00 00 00 00 00 00 00 03 02 00
00 05 01 01 02 c1 c2 00 00 00 00 00 00 00 03 00
00 05 01 01 01 d1 00 00 00 00 00 00 00 00 03 00
02 05 01 01 03 e1 e2 e3 00 00 00 00 00 03 00 00
03 05 00 01 08 80 06 00 01 00 00 40 00 00 03 00
02 12 01 01 00 00 00 00 00 00 00 00 00 03 03 00
00 05 02 01 00 00 00 00 00 00 00 00 00 03 03 01
01 05 00 01 00 00 00 00 00 00 00 00 00 03 03 02
00 7f 01 01 00 00 00 00 00 00 00 00 00 03 03 02
02 05 03 01 00 00 00 00 00 00 00 00 00 03 03 01
03 05 00 01 08 00 09 01 00 34 12 08 00 00 03 00
02 05 01 01 01 f1 00 00 00 00 00 00 00 03 02 00
00 05 01 01 05 01 02 03 04 05 00 00 00 00 03 00
02 05 01 00 00 00 00 00 00 00 00 00 00 03 02 00

// ==== build.f ====
+incdir+bench
logic/usb_xfer_pkg.sv
logic/token_dispatch.sv
logic/bulk_endpoint.sv
logic/setup_parser.sv
logic/handshake_issuer.sv
logic/usb_transaction_top.sv
bench/tb_usb_transaction.sv

// ==== logic/bulk_endpoint.sv ====
module bulk_endpoint (
  input  logic                              clock,
  input  logic                              reset,
  input  usb_xfer_pkg::xfer_e               xfer_i,
  input  logic                              blk_in_ready_i,
  input  logic                              blk_out_ready_i,
  output logic                              blk_start_o,
  output logic                              bulk_done_o,
  output logic                              ack_req_o,
  output logic                              nak_req_o,
  input  logic                              hsk_recv_i,
  input  usb_xfer_pkg::hsk_e                hsk_type_i,
  input  logic                              hsk_sent_i,
  output logic                              usb_send_o,
  output usb_xfer_pkg::pid_e                usb_type_o,
  input  logic                              usb_sent_i,
  input  logic                              usb_tvalid_i,
  output logic                              usb_tready_o,
  input  logic                              usb_tlast_i,
  input  logic [usb_xfer_pkg::BYTE_W-1:0]   usb_tdata_i,
  output logic                              usb_tvalid_o,
  input  logic                              usb_tready_i,
  output logic                              usb_tlast_o,
  output logic [usb_xfer_pkg::BYTE_W-1:0]   usb_tdata_o,
  output logic                              blk_tvalid_o,
  input  logic                              blk_tready_i,
  output logic                              blk_tlast_o,
  output logic [usb_xfer_pkg::BYTE_W-1:0]   blk_tdata_o,
  input  logic                              blk_tvalid_i,
  output logic                              blk_tready_o,
  input  logic                              blk_tlast_i,
  input  logic [usb_xfer_pkg::BYTE_W-1:0]   blk_tdata_i
);

  usb_xfer_pkg::bulk_state_e state_q;
  usb_xfer_pkg::pid_e        type_q;
  logic                      toggle_q;
  logic                      send_q;
  logic                      ack_q;
  logic                      nak_q;
  logic                      in_tx;
  logic                      out_rx;
  logic                      in_last;
  logic                      out_last;
  logic                      tx_start;

  assign in_tx  = state_q == usb_xfer_pkg::BLK_DATI_TX;
  assign out_rx = state_q == usb_xfer_pkg::BLK_DATO_RX;

  // IN stream, source to encoder, passes straight through while sending
  assign usb_tvalid_o = blk_tvalid_i && in_tx;
  assign blk_tready_o = usb_tready_i && in_tx;
  assign usb_tlast_o  = blk_tlast_i;
  assign usb_tdata_o  = blk_tdata_i;

  // OUT stream, decoder to sink; bytes outside a packet are dropped
  assign blk_tvalid_o = usb_tvalid_i && out_rx;
  assign usb_tready_o = out_rx ? blk_tready_i : 1'b1;
  assign blk_tlast_o  = usb_tlast_i;
  assign blk_tdata_o  = usb_tdata_i;

  assign in_last  = usb_tvalid_o && usb_tready_i && blk_tlast_i;
  assign out_last = blk_tvalid_o && blk_tready_i && usb_tlast_i;

  // Data packet goes out for both a full and a zero-data IN
  assign tx_start = state_q == usb_xfer_pkg::BLK_IDLE &&
                    xfer_i == usb_xfer_pkg::XFER_BULK_IN;

  assign blk_start_o = state_q == usb_xfer_pkg::BLK_IDLE &&
                       (xfer_i == usb_xfer_pkg::XFER_BULK_IN ||
                        xfer_i == usb_xfer_pkg::XFER_BULK_OUT);

  // IN ends on the host handshake, OUT ends once our handshake is sent
  assign bulk_done_o = state_q == usb_xfer_pkg::BLK_DATI_ACK && hsk_recv_i ||
                       (state_q == usb_xfer_pkg::BLK_DATO_ACK ||
                        state_q == usb_xfer_pkg::BLK_DATO_NAK) && hsk_sent_i;

  always_ff @(posedge clock) begin
    if (reset) begin
      state_q <= usb_xfer_pkg::BLK_IDLE;
    end else begin
      case (state_q)
        usb_xfer_pkg::BLK_IDLE: begin
          if (xfer_i == usb_xfer_pkg::XFER_BULK_IN) begin
            state_q <= blk_in_ready_i ? usb_xfer_pkg::BLK_DATI_TX : usb_xfer_pkg::BLK_DATI_ZDP;
          end else if (xfer_i == usb_xfer_pkg::XFER_BULK_OUT) begin
            state_q <= blk_out_ready_i ? usb_xfer_pkg::BLK_DATO_RX : usb_xfer_pkg::BLK_DATO_NAK;
          end
        end
        usb_xfer_pkg::BLK_DATI_TX: begin
          if (in_last) begin
            state_q <= usb_xfer_pkg::BLK_DATI_ACK;
          end
        end
        usb_xfer_pkg::BLK_DATI_ZDP: begin
          // Empty packet is complete once the encoder has sent it
          if (usb_sent_i) begin
            state_q <= usb_xfer_pkg::BLK_DATI_ACK;
          end
        end
        usb_xfer_pkg::BLK_DATI_ACK: begin
          if (hsk_recv_i) begin
            state_q <= usb_xfer_pkg::BLK_IDLE;
          end
        end
        usb_xfer_pkg::BLK_DATO_RX: begin
          if (out_last) begin
            state_q <= usb_xfer_pkg::BLK_DATO_ACK;
          end
        end
        usb_xfer_pkg::BLK_DATO_ACK, usb_xfer_pkg::BLK_DATO_NAK: begin
          if (hsk_sent_i) begin
            state_q <= usb_xfer_pkg::BLK_IDLE;
          end
        end
        default: begin
          state_q <= usb_xfer_pkg::BLK_IDLE;
        end
      endcase
    end
  end

  // DATA0/DATA1 bit, advances only on an acknowledged packet
  always_ff @(posedge clock) begin
    if (reset) begin
      toggle_q <= 1'b0;
    end else if (state_q == usb_xfer_pkg::BLK_DATI_ACK && hsk_recv_i &&
                 hsk_type_i == usb_xfer_pkg::HSK_ACK) begin
      toggle_q <= ~toggle_q;
    end else if (state_q == usb_xfer_pkg::BLK_DATO_ACK && hsk_sent_i) begin
      toggle_q <= ~toggle_q;
    end
  end

  // Encoder request, held until the encoder reports the packet sent
  always_ff @(posedge clock) begin
    if (reset) begin
      send_q <= 1'b0;
    end else if (usb_sent_i) begin
      send_q <= 1'b0;
    end else if (tx_start) begin
      send_q <= 1'b1;
    end
  end

  always_ff @(posedge clock) begin
    if (tx_start) begin
      type_q <= toggle_q ? usb_xfer_pkg::PID_DATA1 : usb_xfer_pkg::PID_DATA0;
    end
  end

  // Handshake requests, one pulse each
  always_ff @(posedge clock) begin
    if (reset) begin
      ack_q <= 1'b0;
      nak_q <= 1'b0;
    end else begin
      ack_q <= out_last;
      // Sink busy, so refuse the OUT packet
      nak_q <= state_q == usb_xfer_pkg::BLK_IDLE &&
               xfer_i == usb_xfer_pkg::XFER_BULK_OUT && !blk_out_ready_i;
    end
  end

  assign usb_send_o = send_q;
  assign usb_type_o = type_q;
  assign ack_req_o  = ack_q;
  assign nak_req_o  = nak_q;

endmodule

// ==== logic/handshake_issuer.sv ====
module handshake_issuer (
  input  logic               clock,
  input  logic               reset,
  input  logic               ack_req_i,
  input  logic               nak_req_i,
  input  logic               hsk_sent_i,
  output logic               hsk_send_o,
  output usb_xfer_pkg::hsk_e hsk_type_o
);

  logic               send_q;
  usb_xfer_pkg::hsk_e type_q;

  // Send flag, raised by a request and dropped once the encoder is done
  always_ff @(posedge clock) begin
    if (reset) begin
      send_q <= 1'b0;
    end else if (hsk_sent_i) begin
      send_q <= 1'b0;
    end else if (ack_req_i || nak_req_i) begin
      send_q <= 1'b1;
    end
  end

  // Type stays put while the request is held
  always_ff @(posedge clock) begin
    if (!send_q && (ack_req_i || nak_req_i)) begin
      type_q <= ack_req_i ? usb_xfer_pkg::HSK_ACK : usb_xfer_pkg::HSK_NAK;
    end
  end

  assign hsk_send_o = send_q;
  assign hsk_type_o = type_q;

endmodule

// ==== logic/setup_parser.sv ====
module setup_parser (
  input  logic                              clock,
  input  logic                              reset,
  input  usb_xfer_pkg::xfer_e               xfer_i,
  input  logic                              usb_tvalid_i,
  input  logic                              usb_tlast_i,
  input  logic [usb_xfer_pkg::BYTE_W-1:0]   usb_tdata_i,
  input  logic                              hsk_sent_i,
  output logic                              ack_req_o,
  output logic                              setup_done_o,
  output logic                              ctl_start_o,
  output logic [usb_xfer_pkg::BYTE_W-1:0]   ctl_rtype_o,
  output logic [usb_xfer_pkg::BYTE_W-1:0]   ctl_rargs_o,
  output logic [15:0]                       ctl_value_o,
  output logic [15:0]                       ctl_index_o,
  output logic [15:0]                       ctl_length_o
);

  usb_xfer_pkg::setup_state_e state_q;
  logic [usb_xfer_pkg::BYTE_W-1:0] buf_q [usb_xfer_pkg::SETUP_BYTES];
  // Byte counter, saturates at SETUP_BYTES
  logic [3:0]  cnt_q;
  logic        rx_fire;
  logic        rx_full;
  logic        rx_good;
  logic        ack_q;
  logic        start_q;
  logic [usb_xfer_pkg::BYTE_W-1:0] rtype_q;
  logic [usb_xfer_pkg::BYTE_W-1:0] rargs_q;
  logic [15:0] value_q;
  logic [15:0] index_q;
  logic [15:0] length_q;

  // Receive ready is high outside bulk OUT, so valid alone moves a byte
  assign rx_fire = xfer_i == usb_xfer_pkg::XFER_SETUP && state_q == usb_xfer_pkg::SET_RX &&
                   usb_tvalid_i;
  assign rx_full = cnt_q == 4'(usb_xfer_pkg::SETUP_BYTES);
  // Packet is valid only when tlast lands on byte 7
  assign rx_good = rx_fire && usb_tlast_i &&
                   cnt_q == 4'(usb_xfer_pkg::SETUP_BYTES - 1);

  always_ff @(posedge clock) begin
    if (reset) begin
      state_q <= usb_xfer_pkg::SET_RX;
    end else begin
      case (state_q)
        usb_xfer_pkg::SET_RX: begin
          if (rx_fire && usb_tlast_i) begin
            state_q <= rx_good ? usb_xfer_pkg::SET_ACK : usb_xfer_pkg::SET_DONE;
          end
        end
        usb_xfer_pkg::SET_ACK: begin
          if (hsk_sent_i) begin
            state_q <= usb_xfer_pkg::SET_DONE;
          end
        end
        default: begin
          state_q <= usb_xfer_pkg::SET_RX;
        end
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      cnt_q <= '0;
    end else if (state_q == usb_xfer_pkg::SET_DONE) begin
      cnt_q <= '0;
    end else if (rx_fire && !rx_full) begin
      cnt_q <= cnt_q + 4'd1;
    end
  end

  // Staging buffer, extra bytes beyond eight are not stored
  always_ff @(posedge clock) begin
    if (rx_fire && !rx_full) begin
      buf_q[cnt_q[2:0]] <= usb_tdata_i;
    end
  end

  // Request fields update only after a good packet was ACKed
  always_ff @(posedge clock) begin
    if (state_q == usb_xfer_pkg::SET_ACK && hsk_sent_i) begin
      rtype_q  <= buf_q[0];
      rargs_q  <= buf_q[1];
      // Little-endian, low byte first
      value_q  <= {buf_q[3], buf_q[2]};
      index_q  <= {buf_q[5], buf_q[4]};
      length_q <= {buf_q[7], buf_q[6]};
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      ack_q   <= 1'b0;
      start_q <= 1'b0;
    end else begin
      ack_q   <= rx_good;
      start_q <= state_q == usb_xfer_pkg::SET_ACK && hsk_sent_i;
    end
  end

  assign ack_req_o    = ack_q;
  assign ctl_start_o  = start_q;
  assign setup_done_o = state_q == usb_xfer_pkg::SET_DONE;
  assign ctl_rtype_o  = rtype_q;
  assign ctl_rargs_o  = rargs_q;
  assign ctl_value_o  = value_q;
  assign ctl_index_o  = index_q;
  assign ctl_length_o = length_q;

endmodule

// ==== logic/token_dispatch.sv ====
module token_dispatch (
  input  logic                              clock,
  input  logic                              reset,
  input  logic [usb_xfer_pkg::ADDR_W-1:0]   usb_addr_i,
  input  logic                              tok_recv_i,
  input  usb_xfer_pkg::token_e              tok_type_i,
  input  logic [usb_xfer_pkg::ADDR_W-1:0]   tok_addr_i,
  input  logic [usb_xfer_pkg::ENDP_W-1:0]   tok_endp_i,
  input  logic                              bulk_done_i,
  input  logic                              setup_done_i,
  output usb_xfer_pkg::xfer_e               xfer_o,
  output usb_xfer_pkg::err_e                err_code_o
);

  usb_xfer_pkg::xfer_e xfer_q;
  usb_xfer_pkg::err_e  err_q;
  logic                tok_hit;
  logic                bulk_endp;
  logic                ctrl_endp;

  // Only tokens for our own address are considered
  assign tok_hit   = tok_recv_i && tok_addr_i == usb_addr_i;
  assign bulk_endp = tok_endp_i == usb_xfer_pkg::BULK_ENDPOINT;
  assign ctrl_endp = tok_endp_i == usb_xfer_pkg::CTRL_ENDPOINT;

  always_ff @(posedge clock) begin
    if (reset) begin
      xfer_q <= usb_xfer_pkg::XFER_IDLE;
      err_q  <= usb_xfer_pkg::ERR_NONE;
    end else if (xfer_q == usb_xfer_pkg::XFER_IDLE) begin
      if (tok_hit) begin
        case (tok_type_i)
          usb_xfer_pkg::TOK_IN, usb_xfer_pkg::TOK_OUT: begin
            if (bulk_endp) begin
              xfer_q <= tok_type_i == usb_xfer_pkg::TOK_IN ?
                        usb_xfer_pkg::XFER_BULK_IN : usb_xfer_pkg::XFER_BULK_OUT;
              err_q  <= usb_xfer_pkg::ERR_NONE;
            end else begin
              err_q <= usb_xfer_pkg::ERR_BAD_ENDP;
            end
          end
          usb_xfer_pkg::TOK_SETUP: begin
            // Setup stage only lives on the control endpoint
            if (ctrl_endp) begin
              xfer_q <= usb_xfer_pkg::XFER_SETUP;
              err_q  <= usb_xfer_pkg::ERR_NONE;
            end else begin
              err_q <= usb_xfer_pkg::ERR_BAD_ENDP;
            end
          end
          default: begin
            // SOF and anything else is not handled here
            err_q <= usb_xfer_pkg::ERR_BAD_TOKEN;
          end
        endcase
      end
    end else if (bulk_done_i || setup_done_i) begin
      // Active transfer finished, back to token decoding
      xfer_q <= usb_xfer_pkg::XFER_IDLE;
    end
  end

  assign xfer_o     = xfer_q;
  assign err_code_o = err_q;

endmodule

// ==== logic/usb_transaction_top.sv ====
module usb_transaction_top (
  input  logic                              clock,
  input  logic                              reset,
  input  logic [usb_xfer_pkg::ADDR_W-1:0]   usb_addr_i,
  // Token decoder
  input  logic                              tok_recv_i,
  input  usb_xfer_pkg::token_e              tok_type_i,
  input  logic [usb_xfer_pkg::ADDR_W-1:0]   tok_addr_i,
  input  logic [usb_xfer_pkg::ENDP_W-1:0]   tok_endp_i,
  // Handshakes, host and device
  input  logic                              hsk_recv_i,
  input  usb_xfer_pkg::hsk_e                hsk_type_i,
  output logic                              hsk_send_o,
  input  logic                              hsk_sent_i,
  output usb_xfer_pkg::hsk_e                hsk_type_o,
  // Data packet requests to the encoder
  output logic                              usb_send_o,
  input  logic                              usb_sent_i,
  output usb_xfer_pkg::pid_e                usb_type_o,
  // USB receive stream
  input  logic                              usb_tvalid_i,
  output logic                              usb_tready_o,
  input  logic                              usb_tlast_i,
  input  logic [usb_xfer_pkg::BYTE_W-1:0]   usb_tdata_i,
  // USB transmit stream
  output logic                              usb_tvalid_o,
  input  logic                              usb_tready_i,
  output logic                              usb_tlast_o,
  output logic [usb_xfer_pkg::BYTE_W-1:0]   usb_tdata_o,
  // Bulk endpoint
  input  logic                              blk_in_ready_i,
  input  logic                              blk_out_ready_i,
  output logic                              blk_start_o,
  output logic                              blk_tvalid_o,
  input  logic                              blk_tready_i,
  output logic                              blk_tlast_o,
  output logic [usb_xfer_pkg::BYTE_W-1:0]   blk_tdata_o,
  input  logic                              blk_tvalid_i,
  output logic                              blk_tready_o,
  input  logic                              blk_tlast_i,
  input  logic [usb_xfer_pkg::BYTE_W-1:0]   blk_tdata_i,
  // Setup request
  output logic                              ctl_start_o,
  output logic [usb_xfer_pkg::BYTE_W-1:0]   ctl_rtype_o,
  output logic [usb_xfer_pkg::BYTE_W-1:0]   ctl_rargs_o,
  output logic [15:0]                       ctl_value_o,
  output logic [15:0]                       ctl_index_o,
  output logic [15:0]                       ctl_length_o,
  output usb_xfer_pkg::err_e                err_code_o
);

  usb_xfer_pkg::xfer_e xfer;
  logic bulk_done;
  logic setup_done;
  logic blk_ack_req;
  logic blk_nak_req;
  logic set_ack_req;
  logic ack_req;

  // Bulk and setup never run together, so their ACKs just merge
  assign ack_req = blk_ack_req || set_ack_req;

  token_dispatch u_dispatch (
    .clock        (clock),
    .reset        (reset),
    .usb_addr_i   (usb_addr_i),
    .tok_recv_i   (tok_recv_i),
    .tok_type_i   (tok_type_i),
    .tok_addr_i   (tok_addr_i),
    .tok_endp_i   (tok_endp_i),
    .bulk_done_i  (bulk_done),
    .setup_done_i (setup_done),
    .xfer_o       (xfer),
    .err_code_o   (err_code_o)
  );

  bulk_endpoint u_bulk (
    .clock           (clock),
    .reset           (reset),
    .xfer_i          (xfer),
    .blk_in_ready_i  (blk_in_ready_i),
    .blk_out_ready_i (blk_out_ready_i),
    .blk_start_o     (blk_start_o),
    .bulk_done_o     (bulk_done),
    .ack_req_o       (blk_ack_req),
    .nak_req_o       (blk_nak_req),
    .hsk_recv_i      (hsk_recv_i),
    .hsk_type_i      (hsk_type_i),
    .hsk_sent_i      (hsk_sent_i),
    .usb_send_o      (usb_send_o),
    .usb_type_o      (usb_type_o),
    .usb_sent_i      (usb_sent_i),
    .usb_tvalid_i    (usb_tvalid_i),
    .usb_tready_o    (usb_tready_o),
    .usb_tlast_i     (usb_tlast_i),
    .usb_tdata_i     (usb_tdata_i),
    .usb_tvalid_o    (usb_tvalid_o),
    .usb_tready_i    (usb_tready_i),
    .usb_tlast_o     (usb_tlast_o),
    .usb_tdata_o     (usb_tdata_o),
    .blk_tvalid_o    (blk_tvalid_o),
    .blk_tready_i    (blk_tready_i),
    .blk_tlast_o     (blk_tlast_o),
    .blk_tdata_o     (blk_tdata_o),
    .blk_tvalid_i    (blk_tvalid_i),
    .blk_tready_o    (blk_tready_o),
    .blk_tlast_i     (blk_tlast_i),
    .blk_tdata_i     (blk_tdata_i)
  );

  setup_parser u_setup (
    .clock        (clock),
    .reset        (reset),
    .xfer_i       (xfer),
    .usb_tvalid_i (usb_tvalid_i),
    .usb_tlast_i  (usb_tlast_i),
    .usb_tdata_i  (usb_tdata_i),
    .hsk_sent_i   (hsk_sent_i),
    .ack_req_o    (set_ack_req),
    .setup_done_o (setup_done),
    .ctl_start_o  (ctl_start_o),
    .ctl_rtype_o  (ctl_rtype_o),
    .ctl_rargs_o  (ctl_rargs_o),
    .ctl_value_o  (ctl_value_o),
    .ctl_index_o  (ctl_index_o),
    .ctl_length_o (ctl_length_o)
  );

  handshake_issuer u_hsk (
    .clock      (clock),
    .reset      (reset),
    .ack_req_i  (ack_req),
    .nak_req_i  (blk_nak_req),
    .hsk_sent_i (hsk_sent_i),
    .hsk_send_o (hsk_send_o),
    .hsk_type_o (hsk_type_o)
  );

endmodule

// ==== logic/usb_xfer_pkg.sv ====
package usb_xfer_pkg;

  // Data path and token field widths
  localparam int BYTE_W = 8;
  localparam int ADDR_W = 7;
  localparam int ENDP_W = 4;

  // Endpoints served by this device
  localparam logic [ENDP_W-1:0] BULK_ENDPOINT = 4'd1;
  localparam logic [ENDP_W-1:0] CTRL_ENDPOINT = 4'd0;

  // Setup packet is always eight bytes
  localparam int SETUP_BYTES = 8;

  // Token kinds, as delivered by the packet decoder
  typedef enum logic [1:0] {
    TOK_OUT   = 2'b00,
    TOK_SOF   = 2'b01,
    TOK_IN    = 2'b10,
    TOK_SETUP = 2'b11
  } token_e;

  // Data PIDs, encoder/decoder encoding
  typedef enum logic [1:0] {
    PID_DATA0 = 2'b00,
    PID_DATA1 = 2'b10
  } pid_e;

  // Handshake PIDs
  typedef enum logic [1:0] {
    HSK_ACK = 2'b00,
    HSK_NAK = 2'b10
  } hsk_e;

  // Transfer selected by the token decoder
  typedef enum logic [1:0] {
    XFER_IDLE,
    XFER_BULK_IN,
    XFER_BULK_OUT,
    XFER_SETUP
  } xfer_e;

  // Bulk endpoint FSM
  typedef enum logic [2:0] {
    BLK_IDLE,
    BLK_DATI_TX,
    BLK_DATI_ZDP,
    BLK_DATI_ACK,
    BLK_DATO_RX,
    BLK_DATO_ACK,
    BLK_DATO_NAK
  } bulk_state_e;

  // Setup stage FSM
  typedef enum logic [1:0] {
    SET_RX,
    SET_ACK,
    SET_DONE
  } setup_state_e;

  // Reason the last token was ignored
  typedef enum logic [1:0] {
    ERR_NONE,
    ERR_BAD_ENDP,
    ERR_BAD_TOKEN
  } err_e;

endpackage

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/100ps \
  --top-module tb_usb_transaction -f build.f -o sim_usb

./obj_dir/sim_usb > sim.log 2>&1 || true
cat sim.log

if grep -q ">>> PASS" sim.log; then
  exit 0
else
  exit 1
fi
